// ==== rtl/mwae_log_pkg.sv ====
// Shared widths for the error logger of the memory-write/compare engine.
// RTL modules refer to these by scoped name in their port lists and
// import the package in their body when they need it internally.

package mwae_log_pkg;

  // Memory address carried in the first-error address log
  localparam int ADDR_WIDTH = 64;

  // Observed and expected data words from the pattern checkers
  localparam int PATTERN_WIDTH = 32;

  // Loop counter of the test that found the error
  localparam int LOOP_WIDTH = 8;

  // Byte offset as stored in the log
  localparam int OFFSET_WIDTH = 8;

  // Checker A reports a narrower offset, zero-extended before logging
  localparam int OFFSET_A_WIDTH = 6;

  // Set number within the pattern sequence
  localparam int SET_WIDTH = 4;

  // Address increment in use when the error was seen
  localparam int INCR_WIDTH = 8;

endpackage

// ==== rtl/error_log_sequencer.sv ====
// Decides when the error logs are loaded, reported and cleared.
// Picks checker A over checker B when both flag a miscompare, and falls
// back to a status-only record for write/read slave errors or read poison.
// The host releases the sequencer by clearing the status bit it mirrors back.

module error_log_sequencer (
  input  logic                                     clk,
  input  logic                                     reset_n,
  input  logic                                     i_busy,
  input  logic                                     i_enable_self_check,
  input  logic                                     i_forceful_disable,
  input  logic                                     i_status_reg,
  input  logic                                     i_slverr_write,
  input  logic                                     i_slverr_read,
  input  logic                                     i_poison_read,

  input  logic                                     i_a_error_found,
  input  logic [mwae_log_pkg::PATTERN_WIDTH-1:0]   i_a_observed,
  input  logic [mwae_log_pkg::PATTERN_WIDTH-1:0]   i_a_expected,
  input  logic [mwae_log_pkg::LOOP_WIDTH-1:0]      i_a_loop,
  input  logic [mwae_log_pkg::OFFSET_A_WIDTH-1:0]  i_a_byte_offset,
  input  logic [mwae_log_pkg::SET_WIDTH-1:0]       i_a_set,
  input  logic [mwae_log_pkg::INCR_WIDTH-1:0]      i_a_addr_incr,
  input  logic [mwae_log_pkg::ADDR_WIDTH-1:0]      i_a_address,

  input  logic                                     i_b_error_found,
  input  logic [mwae_log_pkg::PATTERN_WIDTH-1:0]   i_b_observed,
  input  logic [mwae_log_pkg::PATTERN_WIDTH-1:0]   i_b_expected,
  input  logic [mwae_log_pkg::LOOP_WIDTH-1:0]      i_b_loop,
  input  logic [mwae_log_pkg::OFFSET_WIDTH-1:0]    i_b_byte_offset,
  input  logic [mwae_log_pkg::SET_WIDTH-1:0]       i_b_set,
  input  logic [mwae_log_pkg::INCR_WIDTH-1:0]      i_b_addr_incr,
  input  logic [mwae_log_pkg::ADDR_WIDTH-1:0]      i_b_address,

  output logic                                     o_record_first,
  output logic                                     o_record_other,
  output logic                                     o_clear,
  output logic                                     o_record_error,
  output logic [mwae_log_pkg::PATTERN_WIDTH-1:0]   o_observed,
  output logic [mwae_log_pkg::PATTERN_WIDTH-1:0]   o_expected,
  output logic [mwae_log_pkg::LOOP_WIDTH-1:0]      o_loop,
  output logic [mwae_log_pkg::OFFSET_WIDTH-1:0]    o_byte_offset,
  output logic [mwae_log_pkg::SET_WIDTH-1:0]       o_set,
  output logic [mwae_log_pkg::INCR_WIDTH-1:0]      o_addr_incr,
  output logic [mwae_log_pkg::ADDR_WIDTH-1:0]      o_address
);

  import mwae_log_pkg::*;

  logic checker_error;
  logic bus_error;

  enum logic [2:0] {
    IDLE     = 3'd0,
    RECORD   = 3'd1,
    SEND     = 3'd2,
    WAIT     = 3'd3,
    COMPLETE = 3'd4,
    OTHER    = 3'd5
  } state, next_state;

  // Checker A wins whenever its flag is up, so every field follows that flag
  assign o_observed    = i_a_error_found ? i_a_observed  : i_b_observed;
  assign o_expected    = i_a_error_found ? i_a_expected  : i_b_expected;
  assign o_loop        = i_a_error_found ? i_a_loop      : i_b_loop;
  assign o_set         = i_a_error_found ? i_a_set       : i_b_set;
  assign o_addr_incr   = i_a_error_found ? i_a_addr_incr : i_b_addr_incr;
  assign o_address     = i_a_error_found ? i_a_address   : i_b_address;
  assign o_byte_offset = i_a_error_found
                       ? {{(OFFSET_WIDTH - OFFSET_A_WIDTH){1'b0}}, i_a_byte_offset}
                       : i_b_byte_offset;

  // A miscompare only counts when self-checking is turned on
  assign checker_error = i_enable_self_check & (i_a_error_found | i_b_error_found);
  assign bus_error     = i_slverr_write | i_slverr_read | i_poison_read;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state <= IDLE;
    end
    else if (i_forceful_disable)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= next_state;
    end
  end

  always_comb
  begin
    next_state     = state;
    o_record_first = 1'b0;
    o_record_other = 1'b0;
    o_record_error = 1'b0;
    o_clear        = 1'b0;

    case (state)
      IDLE:
      begin
        // Errors are only looked at while a test is running
        if (i_busy && checker_error)
        begin
          next_state = RECORD;
        end
        else if (i_busy && bus_error)
        begin
          next_state = OTHER;
        end
      end

      RECORD:
      begin
        o_record_first = 1'b1;
        next_state     = SEND;
      end

      OTHER:
      begin
        o_record_other = 1'b1;
        next_state     = SEND;
      end

      SEND:
      begin
        o_record_error = 1'b1;
        next_state     = WAIT;
      end

      WAIT:
      begin
        // Hold here until the host has dropped the status bit
        if (!i_status_reg)
        begin
          o_clear    = 1'b1;
          next_state = COMPLETE;
        end
      end

      COMPLETE:
      begin
        next_state = IDLE;
      end

      default:
      begin
        next_state = IDLE;
      end
    endcase
  end

endmodule

// ==== rtl/error_log_bank.sv ====
// Host-visible error logs of the memory-write/compare engine.
// A full record captures the whole miscompare, a status-only record marks a
// bus error, and a clear or a new test start empties everything.

module error_log_bank (
  input  logic                                    clk,
  input  logic                                    reset_n,
  input  logic                                    i_set_to_busy,
  input  logic                                    i_record_first,
  input  logic                                    i_record_other,
  input  logic                                    i_clear,

  input  logic [mwae_log_pkg::PATTERN_WIDTH-1:0]  i_observed,
  input  logic [mwae_log_pkg::PATTERN_WIDTH-1:0]  i_expected,
  input  logic [mwae_log_pkg::LOOP_WIDTH-1:0]     i_loop,
  input  logic [mwae_log_pkg::OFFSET_WIDTH-1:0]   i_byte_offset,
  input  logic [mwae_log_pkg::SET_WIDTH-1:0]      i_set,
  input  logic [mwae_log_pkg::INCR_WIDTH-1:0]     i_addr_incr,
  input  logic [mwae_log_pkg::ADDR_WIDTH-1:0]     i_address,

  output logic [mwae_log_pkg::PATTERN_WIDTH-1:0]  o_observed_pattern,
  output logic [mwae_log_pkg::PATTERN_WIDTH-1:0]  o_expected_pattern,
  output logic                                    o_error_status,
  output logic [mwae_log_pkg::LOOP_WIDTH-1:0]     o_loop_number,
  output logic [mwae_log_pkg::OFFSET_WIDTH-1:0]   o_byte_offset,
  output logic [mwae_log_pkg::SET_WIDTH-1:0]      o_set_number,
  output logic [mwae_log_pkg::INCR_WIDTH-1:0]     o_address_increment,
  output logic [mwae_log_pkg::ADDR_WIDTH-1:0]     o_first_error_address
);

  logic log_clear;

  assign log_clear = i_clear | i_set_to_busy;

  // Only a full record carries data patterns into the pattern log
  always_ff @(posedge clk)
  begin
    if (!reset_n || log_clear)
    begin
      o_observed_pattern <= '0;
      o_expected_pattern <= '0;
    end
    else if (i_record_first)
    begin
      o_observed_pattern <= i_observed;
      o_expected_pattern <= i_expected;
    end
  end

  // Status log is written by both kinds of record
  always_ff @(posedge clk)
  begin
    if (!reset_n || log_clear)
    begin
      o_error_status <= 1'b0;
      o_loop_number  <= '0;
      o_byte_offset  <= '0;
    end
    else if (i_record_first)
    begin
      o_error_status <= 1'b1;
      o_loop_number  <= i_loop;
      o_byte_offset  <= i_byte_offset;
    end
    else if (i_record_other)
    begin
      // A bus error has no byte position of its own
      o_error_status <= 1'b1;
      o_loop_number  <= i_loop;
      o_byte_offset  <= '0;
    end
  end

  // Set and increment in use at the failing access
  always_ff @(posedge clk)
  begin
    if (!reset_n || log_clear)
    begin
      o_set_number        <= '0;
      o_address_increment <= '0;
    end
    else if (i_record_first)
    begin
      o_set_number        <= i_set;
      o_address_increment <= i_addr_incr;
    end
  end

  // Address of the first miscompare
  always_ff @(posedge clk)
  begin
    if (!reset_n || log_clear)
    begin
      o_first_error_address <= '0;
    end
    else if (i_record_first)
    begin
      o_first_error_address <= i_address;
    end
  end

endmodule

// ==== rtl/mwae_debug_logs.sv ====
// Top of the error logger. The sequencer picks the error and orders the
// record, report and clear steps, and the log bank holds what the host reads.
// A new test start clears the logs directly without going through the sequencer.

module mwae_debug_logs (
  input  logic                                     clk,
  input  logic                                     reset_n,
  input  logic                                     i_set_to_busy,
  input  logic                                     i_busy,
  input  logic                                     i_enable_self_check,
  input  logic                                     i_forceful_disable,
  input  logic                                     i_status_reg,
  input  logic                                     i_slverr_write,
  input  logic                                     i_slverr_read,
  input  logic                                     i_poison_read,

  input  logic                                     i_a_error_found,
  input  logic [mwae_log_pkg::PATTERN_WIDTH-1:0]   i_a_observed,
  input  logic [mwae_log_pkg::PATTERN_WIDTH-1:0]   i_a_expected,
  input  logic [mwae_log_pkg::LOOP_WIDTH-1:0]      i_a_loop,
  input  logic [mwae_log_pkg::OFFSET_A_WIDTH-1:0]  i_a_byte_offset,
  input  logic [mwae_log_pkg::SET_WIDTH-1:0]       i_a_set,
  input  logic [mwae_log_pkg::INCR_WIDTH-1:0]      i_a_addr_incr,
  input  logic [mwae_log_pkg::ADDR_WIDTH-1:0]      i_a_address,

  input  logic                                     i_b_error_found,
  input  logic [mwae_log_pkg::PATTERN_WIDTH-1:0]   i_b_observed,
  input  logic [mwae_log_pkg::PATTERN_WIDTH-1:0]   i_b_expected,
  input  logic [mwae_log_pkg::LOOP_WIDTH-1:0]      i_b_loop,
  input  logic [mwae_log_pkg::OFFSET_WIDTH-1:0]    i_b_byte_offset,
  input  logic [mwae_log_pkg::SET_WIDTH-1:0]       i_b_set,
  input  logic [mwae_log_pkg::INCR_WIDTH-1:0]      i_b_addr_incr,
  input  logic [mwae_log_pkg::ADDR_WIDTH-1:0]      i_b_address,

  output logic [mwae_log_pkg::PATTERN_WIDTH-1:0]   o_observed_pattern,
  output logic [mwae_log_pkg::PATTERN_WIDTH-1:0]   o_expected_pattern,
  output logic                                     o_error_status,
  output logic [mwae_log_pkg::LOOP_WIDTH-1:0]      o_loop_number,
  output logic [mwae_log_pkg::OFFSET_WIDTH-1:0]    o_byte_offset,
  output logic [mwae_log_pkg::SET_WIDTH-1:0]       o_set_number,
  output logic [mwae_log_pkg::INCR_WIDTH-1:0]      o_address_increment,
  output logic [mwae_log_pkg::ADDR_WIDTH-1:0]      o_first_error_address,
  output logic                                     o_record_error
);

  import mwae_log_pkg::*;

  // Commands from the sequencer to the log bank
  logic record_first;
  logic record_other;
  logic clear;

  // Fields of the checker that won the priority selection
  logic [PATTERN_WIDTH-1:0] sel_observed;
  logic [PATTERN_WIDTH-1:0] sel_expected;
  logic [LOOP_WIDTH-1:0]    sel_loop;
  logic [OFFSET_WIDTH-1:0]  sel_byte_offset;
  logic [SET_WIDTH-1:0]     sel_set;
  logic [INCR_WIDTH-1:0]    sel_addr_incr;
  logic [ADDR_WIDTH-1:0]    sel_address;

  error_log_sequencer sequencer0 (
    .clk                 (clk),
    .reset_n             (reset_n),
    .i_busy              (i_busy),
    .i_enable_self_check (i_enable_self_check),
    .i_forceful_disable  (i_forceful_disable),
    .i_status_reg        (i_status_reg),
    .i_slverr_write      (i_slverr_write),
    .i_slverr_read       (i_slverr_read),
    .i_poison_read       (i_poison_read),
    .i_a_error_found     (i_a_error_found),
    .i_a_observed        (i_a_observed),
    .i_a_expected        (i_a_expected),
    .i_a_loop            (i_a_loop),
    .i_a_byte_offset     (i_a_byte_offset),
    .i_a_set             (i_a_set),
    .i_a_addr_incr       (i_a_addr_incr),
    .i_a_address         (i_a_address),
    .i_b_error_found     (i_b_error_found),
    .i_b_observed        (i_b_observed),
    .i_b_expected        (i_b_expected),
    .i_b_loop            (i_b_loop),
    .i_b_byte_offset     (i_b_byte_offset),
    .i_b_set             (i_b_set),
    .i_b_addr_incr       (i_b_addr_incr),
    .i_b_address         (i_b_address),
    .o_record_first      (record_first),
    .o_record_other      (record_other),
    .o_clear             (clear),
    .o_record_error      (o_record_error),
    .o_observed          (sel_observed),
    .o_expected          (sel_expected),
    .o_loop              (sel_loop),
    .o_byte_offset       (sel_byte_offset),
    .o_set               (sel_set),
    .o_addr_incr         (sel_addr_incr),
    .o_address           (sel_address)
  );

  error_log_bank bank0 (
    .clk                   (clk),
    .reset_n               (reset_n),
    .i_set_to_busy         (i_set_to_busy),
    .i_record_first        (record_first),
    .i_record_other        (record_other),
    .i_clear               (clear),
    .i_observed            (sel_observed),
    .i_expected            (sel_expected),
    .i_loop                (sel_loop),
    .i_byte_offset         (sel_byte_offset),
    .i_set                 (sel_set),
    .i_addr_incr           (sel_addr_incr),
    .i_address             (sel_address),
    .o_observed_pattern    (o_observed_pattern),
    .o_expected_pattern    (o_expected_pattern),
    .o_error_status        (o_error_status),
    .o_loop_number         (o_loop_number),
    .o_byte_offset         (o_byte_offset),
    .o_set_number          (o_set_number),
    .o_address_increment   (o_address_increment),
    .o_first_error_address (o_first_error_address)
  );

endmodule

// ==== verif/error_log_sequencer_asserts.sv ====
// Protocol checks on the error log sequencer.
// Bound into error_log_sequencer from the testbench top.

module error_log_sequencer_asserts (
  input logic clk,
  input logic reset_n,
  input logic i_status_reg,
  input logic o_record_first,
  input logic o_record_other,
  input logic o_clear,
  input logic o_record_error
);

  timeunit 1ns;
  timeprecision 1ps;

  // Number of property failures seen so far
  int failures = 0;

  // The report strobe is a single-cycle pulse
  report_single_cycle: assert property (@(posedge clk) disable iff (!reset_n)
    o_record_error |=> !o_record_error)
    else
    begin
      failures++;
      $error("o_record_error stayed high for two cycles");
    end

  record_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
    !(o_record_first && o_record_other))
    else
    begin
      failures++;
      $error("Full and status-only record strobes are high together");
    end

  // Logs are only emptied once the host has dropped the status bit
  clear_after_release: assert property (@(posedge clk) disable iff (!reset_n)
    o_clear |-> !i_status_reg)
    else
    begin
      failures++;
      $error("o_clear asserted while i_status_reg is high");
    end

endmodule

// ==== verif/tb_tasks.svh ====
// Directed tests for the error logger, included into the testbench top.
// The host model mirrors the status bit in the cycle it sees the report
// strobe and drops it again after a random hold.

task automatic clear_error_inputs();
  i_a_error_found = 1'b0;
  i_b_error_found = 1'b0;
  i_slverr_write  = 1'b0;
  i_slverr_read   = 1'b0;
  i_poison_read   = 1'b0;
endtask

task automatic randomize_checkers();
  i_a_observed    = PATTERN_WIDTH'(take_bits(PATTERN_WIDTH));
  i_a_expected    = PATTERN_WIDTH'(take_bits(PATTERN_WIDTH));
  i_a_loop        = LOOP_WIDTH'(take_bits(LOOP_WIDTH));
  i_a_byte_offset = OFFSET_A_WIDTH'(take_bits(OFFSET_A_WIDTH));
  i_a_set         = SET_WIDTH'(take_bits(SET_WIDTH));
  i_a_addr_incr   = INCR_WIDTH'(take_bits(INCR_WIDTH));
  i_a_address     = ADDR_WIDTH'(take_bits(ADDR_WIDTH));
  i_b_observed    = PATTERN_WIDTH'(take_bits(PATTERN_WIDTH));
  i_b_expected    = PATTERN_WIDTH'(take_bits(PATTERN_WIDTH));
  i_b_loop        = LOOP_WIDTH'(take_bits(LOOP_WIDTH));
  i_b_byte_offset = OFFSET_WIDTH'(take_bits(OFFSET_WIDTH));
  i_b_set         = SET_WIDTH'(take_bits(SET_WIDTH));
  i_b_addr_incr   = INCR_WIDTH'(take_bits(INCR_WIDTH));
  i_b_address     = ADDR_WIDTH'(take_bits(ADDR_WIDTH));
endtask

// Checker A wins whenever it reports and its 6-bit offset is zero-extended
task automatic expect_full_record(input logic from_a);
  exp_status   = 1'b1;
  exp_observed = from_a ? i_a_observed : i_b_observed;
  exp_expected = from_a ? i_a_expected : i_b_expected;
  exp_loop     = from_a ? i_a_loop : i_b_loop;
  exp_offset   = from_a ? OFFSET_WIDTH'(i_a_byte_offset) : i_b_byte_offset;
  exp_set      = from_a ? i_a_set : i_b_set;
  exp_incr     = from_a ? i_a_addr_incr : i_b_addr_incr;
  exp_address  = from_a ? i_a_address : i_b_address;
endtask

task automatic wait_for_report();
  int cycles;
  cycles = 0;
  do
  begin
    @(negedge clk);
    cycles++;
  end
  while (!o_record_error && cycles < WAIT_LIMIT);
  if (!o_record_error)
  begin
    $display("Timed out after %0d cycles waiting for o_record_error", cycles);
    abort_run();
  end
  // Strobe comes one cycle after the edge that samples the error
  compare_field("o_record_error latency", LOOP_WIDTH'(cycles), LOOP_WIDTH'(2));
  i_status_reg = 1'b1;
  clear_error_inputs();
  check_logs();
endtask

task automatic release_status();
  int hold;
  int i;
  hold = 1 + int'(take_bits(3));
  for (i = 0; i < hold; i++)
  begin
    @(negedge clk);
    compare_bit("o_record_error", o_record_error, 1'b0);
  end
  check_logs();
  i_status_reg = 1'b0;
  @(negedge clk);
  set_expected_zero();
  check_logs();
  // One more cycle in COMPLETE before the sequencer is back in IDLE
  @(negedge clk);
endtask

task automatic test_idle_ignored();
  int i;
  i_enable_self_check = 1'b1;
  i_a_error_found     = 1'b1;
  i_b_error_found     = 1'b1;
  i_slverr_write      = 1'b1;
  i_poison_read       = 1'b1;
  set_expected_zero();
  for (i = 0; i < 8; i++)
  begin
    @(negedge clk);
    compare_bit("o_record_error", o_record_error, 1'b0);
    check_logs();
  end
  clear_error_inputs();
  i_busy = 1'b1;
endtask

task automatic test_checker_error(input logic use_a, input logic use_b);
  randomize_checkers();
  // Upper offset bits set so a logged B offset shows its full width
  i_b_byte_offset = i_b_byte_offset | 8'hc0;
  i_a_error_found = use_a;
  i_b_error_found = use_b;
  expect_full_record(use_a);
  wait_for_report();
  release_status();
endtask

task automatic test_disable_then_bus_error();
  int i;
  randomize_checkers();
  i_a_error_found = 1'b1;
  expect_full_record(1'b1);
  wait_for_report();
  @(negedge clk);
  i_forceful_disable = 1'b1;
  @(negedge clk);
  i_forceful_disable = 1'b0;
  i_status_reg       = 1'b0;
  for (i = 0; i < 4; i++)
  begin
    @(negedge clk);
    compare_bit("o_record_error", o_record_error, 1'b0);
    check_logs();
  end
  // Status-only entry keeps patterns, set, increment and address
  randomize_checkers();
  i_enable_self_check = 1'b0;
  i_b_error_found     = 1'b1;
  i_slverr_read       = 1'b1;
  exp_loop            = i_b_loop;
  exp_offset          = '0;
  wait_for_report();
  release_status();
  i_enable_self_check = 1'b1;
endtask

task automatic test_set_to_busy();
  randomize_checkers();
  i_a_error_found = 1'b1;
  expect_full_record(1'b1);
  wait_for_report();
  i_set_to_busy = 1'b1;
  @(negedge clk);
  i_set_to_busy = 1'b0;
  set_expected_zero();
  check_logs();
  release_status();
endtask

// ==== verif/tb_mwae_debug_logs.sv ====
// Testbench for the error logger top level. Drives both pattern checkers,
// the bus error lines and a host model on the falling edge, and checks the
// logs that the host reads back. The directed tests come from tb_tasks.svh.

module tb_mwae_debug_logs;

  timeunit 1ns;
  timeprecision 1ps;

  import mwae_log_pkg::*;

  localparam int WAIT_LIMIT = 32;

  logic                      clk = 1'b0;
  logic                      reset_n;
  logic                      i_set_to_busy, i_busy, i_enable_self_check, i_forceful_disable;
  logic                      i_status_reg, i_slverr_write, i_slverr_read, i_poison_read;
  logic                      i_a_error_found, i_b_error_found;
  logic [PATTERN_WIDTH-1:0]  i_a_observed, i_a_expected, i_b_observed, i_b_expected;
  logic [LOOP_WIDTH-1:0]     i_a_loop, i_b_loop;
  logic [OFFSET_A_WIDTH-1:0] i_a_byte_offset;
  logic [OFFSET_WIDTH-1:0]   i_b_byte_offset;
  logic [SET_WIDTH-1:0]      i_a_set, i_b_set;
  logic [INCR_WIDTH-1:0]     i_a_addr_incr, i_b_addr_incr;
  logic [ADDR_WIDTH-1:0]     i_a_address, i_b_address;

  logic [PATTERN_WIDTH-1:0]  o_observed_pattern, o_expected_pattern;
  logic                      o_error_status, o_record_error;
  logic [LOOP_WIDTH-1:0]     o_loop_number;
  logic [OFFSET_WIDTH-1:0]   o_byte_offset;
  logic [SET_WIDTH-1:0]      o_set_number;
  logic [INCR_WIDTH-1:0]     o_address_increment;
  logic [ADDR_WIDTH-1:0]     o_first_error_address;

  // Values the logs should hold, worked out from the logging rules
  logic [PATTERN_WIDTH-1:0]  exp_observed, exp_expected;
  logic                      exp_status;
  logic [LOOP_WIDTH-1:0]     exp_loop;
  logic [OFFSET_WIDTH-1:0]   exp_offset;
  logic [SET_WIDTH-1:0]      exp_set;
  logic [INCR_WIDTH-1:0]     exp_incr;
  logic [ADDR_WIDTH-1:0]     exp_address;

  logic [31:0]               lfsr_state = 32'hb54647a1;

  mwae_debug_logs dut0 (.*);

  bind error_log_sequencer error_log_sequencer_asserts asserts0 (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] lfsr_next(logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'ha3000000) : (state >> 1);
  endfunction

  // One LFSR step per bit handed out
  function automatic logic [63:0] take_bits(int count);
    logic [63:0] value;
    int i;
    value = '0;
    for (i = 0; i < count; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[62:0], lfsr_state[0]};
    end
    return value;
  endfunction

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic compare_pattern(string name, logic [PATTERN_WIDTH-1:0] actual,
                                 logic [PATTERN_WIDTH-1:0] expected);
    if (actual !== expected)
    begin
      $display("[FAIL] t=%0t %s: got 0x%h, expected 0x%h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic compare_address(string name, logic [ADDR_WIDTH-1:0] actual,
                                 logic [ADDR_WIDTH-1:0] expected);
    if (actual !== expected)
    begin
      $display("[FAIL] t=%0t %s: got 0x%h, expected 0x%h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic compare_field(string name, logic [LOOP_WIDTH-1:0] actual,
                               logic [LOOP_WIDTH-1:0] expected);
    if (actual !== expected)
    begin
      $display("[FAIL] t=%0t %s: got 0x%h, expected 0x%h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic compare_bit(string name, logic actual, logic expected);
    if (actual !== expected)
    begin
      $display("[FAIL] t=%0t %s: got %b, expected %b", $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic set_expected_zero();
    exp_observed = '0;
    exp_expected = '0;
    exp_status   = 1'b0;
    exp_loop     = '0;
    exp_offset   = '0;
    exp_set      = '0;
    exp_incr     = '0;
    exp_address  = '0;
  endtask

  task automatic check_logs();
    compare_pattern("o_observed_pattern", o_observed_pattern, exp_observed);
    compare_pattern("o_expected_pattern", o_expected_pattern, exp_expected);
    compare_bit("o_error_status", o_error_status, exp_status);
    compare_field("o_loop_number", o_loop_number, exp_loop);
    compare_field("o_byte_offset", o_byte_offset, exp_offset);
    compare_field("o_set_number", LOOP_WIDTH'(o_set_number), LOOP_WIDTH'(exp_set));
    compare_field("o_address_increment", o_address_increment, exp_incr);
    compare_address("o_first_error_address", o_first_error_address, exp_address);
  endtask

  `include "tb_tasks.svh"

  initial
  begin
    reset_n             = 1'b0;
    i_set_to_busy       = 1'b0;
    i_busy              = 1'b0;
    i_enable_self_check = 1'b0;
    i_forceful_disable  = 1'b0;
    i_status_reg        = 1'b0;
    clear_error_inputs();
    randomize_checkers();
    repeat (10) @(negedge clk);
    reset_n = 1'b1;

    test_idle_ignored();
    // A alone, then A and B together, then B alone
    test_checker_error(1'b1, 1'b0);
    test_checker_error(1'b1, 1'b1);
    test_checker_error(1'b0, 1'b1);
    test_disable_then_bus_error();
    test_set_to_busy();

    if (dut0.sequencer0.asserts0.failures != 0)
    begin
      $display("Sequencer protocol assertions failed during the run");
      abort_run();
    end
    else
    begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

// ==== flist.f ====
+incdir+verif
rtl/mwae_log_pkg.sv
rtl/error_log_sequencer.sv
rtl/error_log_bank.sv
rtl/mwae_debug_logs.sv
verif/error_log_sequencer_asserts.sv
verif/tb_mwae_debug_logs.sv

// ==== Makefile ====
# Verilator build and run for the error logger testbench

VERILATOR ?= verilator
TOP       ?= tb_mwae_debug_logs
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(filter-out +%,$(shell cat $(FLIST)))
HEADERS := $(wildcard verif/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation ended without passing"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
